/* sim.f */
+incdir+common
common/result_pkg.sv
common/serial_pkg.sv
common/dispatch_if.sv
src/output_dispatch.sv
uart_tx/uart_tx_core.sv
uart_tx/tx_sequencer.sv
display/seg_display.sv
src/output_top.sv
verification/tb_output_top.sv

/* Makefile */
TB_TOP = tb_output_top

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f sim.f --top-module output_top

sim:
	verilator --binary --timing -f sim.f --top-module $(TB_TOP) --Mdir obj_dir -o sim_bin
	./obj_dir/sim_bin | tee sim.log
	grep -q "Simulation passed" sim.log

clean:
	rm -rf obj_dir sim.log

/* verification/tb_output_top.sv */
`include "out_config.svh"

module tb_output_top import result_pkg::*, serial_pkg::*; ();

    localparam int CLKS  = `OUT_CLKS_PER_BIT;
    localparam int SCAN  = `OUT_SCAN_DIV;
    localparam int FRAME = 10 * CLKS;
    // one transfer with its gaps, the display sampling and some handshake slack
    localparam int XFER_CYCLES = 4 * FRAME + 3 * `OUT_BYTE_GAP + 8 * SCAN + 30;
    localparam int NUM_XFERS   = 12;
    localparam int CYCLE_LIMIT = 5 * (NUM_XFERS * XFER_CYCLES + 16);

    // one-hot flags, bit 0 is read and bit 5 is dot
    localparam op_code_t OPC_READ = 6'b000001;
    localparam op_code_t OPC_SUM  = 6'b000010;
    localparam op_code_t OPC_AVG  = 6'b000100;
    localparam op_code_t OPC_EUC  = 6'b001000;
    localparam op_code_t OPC_MAN  = 6'b010000;
    localparam op_code_t SHOW_MASK = OPC_AVG | OPC_EUC | OPC_MAN;

    logic     clk;
    logic     rst_n;
    logic     req;
    op_code_t op_code;
    result_t  result_data;
    logic     ack;
    logic     tx;
    seg_t     seg;
    anode_t   an;

    byte_t       rx_q[$];
    logic [31:0] rng_state;
    int          checks;
    int          value_errors;
    int          other_errors;
    int          cycle_count;

    output_top dut0 (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .op_code     (op_code),
        .result_data (result_data),
        .ack         (ack),
        .tx          (tx),
        .seg         (seg),
        .an          (an)
    );

    always #2 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Simulation failed");
            $finish;
        end
    end

    // ============================================================
    // serial line decoder, samples each bit in its middle
    // ============================================================
    initial begin : line_decoder
        byte_t data;
        forever begin
            @(negedge clk);
            if (rst_n && tx === 1'b0) begin
                repeat (CLKS / 2 - 1) @(negedge clk);
                if (tx !== 1'b0) begin
                    $display("line decoder: start bit not low in its middle at %0t", $time);
                    other_errors++;
                end
                for (int i = 0; i < 8; i++) begin
                    repeat (CLKS) @(negedge clk);
                    data[i] = tx;
                end
                repeat (CLKS) @(negedge clk);
                if (tx !== 1'b1) begin
                    $display("line decoder: stop bit not high at %0t", $time);
                    other_errors++;
                end
                rx_q.push_back(data);
            end
        end
    end

    // ============================================================
    // compare tasks and reference helpers
    // ============================================================
    task automatic check_byte(input string name, input byte_t exp, input byte_t act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_seg(input string name, input seg_t exp, input seg_t act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_anode(input string name, input anode_t exp, input anode_t act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_ack(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, act);
            value_errors++;
        end
    endtask

    // lit segments for a hex digit, a in bit 6 down to g in bit 0
    function automatic seg_t segments_on(input digit_t d);
        case (d)
            4'h0: return 7'h7E;
            4'h1: return 7'h30;
            4'h2: return 7'h6D;
            4'h3: return 7'h79;
            4'h4: return 7'h33;
            4'h5: return 7'h5B;
            4'h6: return 7'h5F;
            4'h7: return 7'h70;
            4'h8: return 7'h7F;
            4'h9: return 7'h7B;
            4'hA: return 7'h77;
            4'hB: return 7'h1F;
            4'hC: return 7'h4E;
            4'hD: return 7'h3D;
            4'hE: return 7'h4F;
            default: return 7'h47;
        endcase
    endfunction

    // index of the single low anode, or -1 when the pattern selects no single digit
    function automatic int lit_digit(input anode_t a);
        for (int i = 0; i < 8; i++) begin
            if (a == anode_t'(~(8'd1 << i))) return i;
        end
        return -1;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic draw_result(output result_t v);
        rng_state = xorshift32(rng_state);
        v = rng_state;
    endtask

    task automatic check_display(input result_t value);
        logic [7:0] seen;
        int         k;
        digit_t     nib;
        seen = '0;
        repeat (8 * SCAN) begin
            @(negedge clk);
            k = lit_digit(an);
            if (k < 0) begin
                $display("display: anode pattern %h does not select one digit", an);
                other_errors++;
            end else begin
                nib = value[4 * k +: 4];
                check_seg($sformatf("seg digit %0d", k), ~segments_on(nib), seg);
                seen[k] = 1'b1;
            end
        end
        if (seen != 8'hFF) begin
            $display("display: digits %h were never lit over eight scan periods", ~seen);
            other_errors++;
        end
    endtask

    task automatic check_dark();
        logic bad;
        bad = 1'b0;
        repeat (8 * SCAN) begin
            @(negedge clk);
            if (!bad && (an !== 8'hFF || seg !== 7'h7F)) begin
                check_anode("an", 8'hFF, an);
                check_seg("seg", 7'h7F, seg);
                bad = 1'b1;
            end
        end
    endtask

    // full four-phase transfer, then the bytes and the display are checked
    task automatic send_result(input op_code_t op, input result_t value, input int hold);
        logic show;
        logic dark_bad;
        int   waited;
        show     = |(op & SHOW_MASK);
        dark_bad = 1'b0;
        waited   = 0;
        rx_q.delete();
        @(negedge clk);
        op_code     = op;
        result_data = value;
        req         = 1'b1;
        while (ack !== 1'b1) begin
            @(negedge clk);
            waited++;
            // the display takes the new flag two cycles after req
            if (!show && waited >= 3 && an !== 8'hFF && !dark_bad) begin
                check_anode("an", 8'hFF, an);
                dark_bad = 1'b1;
            end
        end
        if (rx_q.size() != 4) begin
            $display("handshake: ack rose after %0d of 4 bytes", rx_q.size());
            other_errors++;
        end
        repeat (hold) begin
            @(negedge clk);
            check_ack("ack", 1'b1, ack);
        end
        req = 1'b0;
        while (ack !== 1'b0) @(negedge clk);
        for (int i = 0; i < 4; i++) begin
            if (i < rx_q.size()) begin
                check_byte($sformatf("rx byte %0d", i), value[8 * (3 - i) +: 8], rx_q[i]);
            end
        end
        if (show) check_display(value);
        else check_dark();
    endtask

    // ============================================================
    // directed tests
    // ============================================================
    task automatic test_reset_state();
        check_ack("ack", 1'b0, ack);
        check_ack("tx", 1'b1, tx);
        check_anode("an", 8'hFF, an);
        check_seg("seg", 7'h7F, seg);
    endtask

    task automatic test_shown_ops();
        result_t v;
        draw_result(v);
        send_result(OPC_AVG, v, 2);
        draw_result(v);
        send_result(OPC_EUC, v, 2);
        draw_result(v);
        send_result(OPC_MAN, v, 2);
    endtask

    task automatic test_dark_ops();
        result_t v;
        draw_result(v);
        send_result(OPC_SUM, v, 2);
        draw_result(v);
        send_result(OPC_READ, v, 2);
    endtask

    task automatic test_ack_hold();
        result_t v;
        draw_result(v);
        send_result(OPC_AVG, v, 12);
        draw_result(v);
        send_result(OPC_MAN, v, 12);
    endtask

    task automatic test_back_to_back();
        op_code_t ops[5];
        result_t  v;
        ops = '{OPC_AVG, OPC_SUM, OPC_EUC, OPC_READ, OPC_MAN};
        for (int i = 0; i < 5; i++) begin
            draw_result(v);
            send_result(ops[i], v, 1);
        end
    endtask

    initial begin
        clk          = 1'b0;
        rst_n        = 1'b0;
        req          = 1'b0;
        op_code      = '0;
        result_data  = '0;
        rng_state    = 32'h26ff_cca9;
        checks       = 0;
        value_errors = 0;
        other_errors = 0;
        cycle_count  = 0;
        repeat (16) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset_state();
        test_shown_ops();
        test_dark_ops();
        test_ack_hold();
        test_back_to_back();
        $display("checks %0d, value errors %0d, other errors %0d",
                 checks, value_errors, other_errors);
        if (value_errors == 0 && other_errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

/* src/output_top.sv */
module output_top import result_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  op_code_t op_code,
    input  result_t  result_data,
    output logic     ack,
    output logic     tx,
    output seg_t     seg,
    output anode_t   an
);

    // one bus from the dispatcher fans out to both output paths
    dispatch_if disp_bus ();

    output_dispatch u_output_dispatch (
        .clk         (clk),
        .rst_n       (rst_n),
        .req         (req),
        .op_code     (op_code),
        .result_data (result_data),
        .ack         (ack),
        .dp          (disp_bus.dispatcher)
    );

    // serial path, four bytes MSB first
    tx_sequencer u_tx_sequencer (
        .clk   (clk),
        .rst_n (rst_n),
        .sp    (disp_bus.sender),
        .tx    (tx)
    );

    seg_display u_seg_display (
        .clk   (clk),
        .rst_n (rst_n),
        .dsp   (disp_bus.display),
        .seg   (seg),
        .an    (an)
    );

endmodule

/* display/seg_display.sv */
`include "out_config.svh"

module seg_display import result_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    dispatch_if.display dsp,
    output seg_t   seg,
    output anode_t an
);

    localparam int DIV_W = $clog2(`OUT_SCAN_DIV + 1);

    result_t          value_q;
    logic             show_q;
    logic [DIV_W-1:0] div_cnt;
    logic [2:0]       digit_idx;
    digit_t           nibble;

    // hex to seven segments, active low with segment a in the top bit
    function automatic seg_t hex_to_seg(input digit_t d);
        case (d)
            4'h0: return 7'b000_0001;
            4'h1: return 7'b100_1111;
            4'h2: return 7'b001_0010;
            4'h3: return 7'b000_0110;
            4'h4: return 7'b100_1100;
            4'h5: return 7'b010_0100;
            4'h6: return 7'b010_0000;
            4'h7: return 7'b000_1111;
            4'h8: return 7'b000_0000;
            4'h9: return 7'b000_0100;
            4'hA: return 7'b000_1000;
            4'hB: return 7'b110_0000;
            4'hC: return 7'b011_0001;
            4'hD: return 7'b100_0010;
            4'hE: return 7'b011_0000;
            default: return 7'b011_1000;
        endcase
    endfunction

    // ============================================================
    // latch and scan
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            show_q        <= 1'b0;
            dsp.disp_done <= 1'b0;
            div_cnt       <= '0;
            digit_idx     <= '0;
        end else begin
            dsp.disp_done <= dsp.start;
            if (dsp.start) begin
                // a new value restarts the scan at digit 0
                show_q    <= dsp.show;
                div_cnt   <= '0;
                digit_idx <= '0;
            end else if (div_cnt == DIV_W'(`OUT_SCAN_DIV - 1)) begin
                div_cnt   <= '0;
                digit_idx <= digit_idx + 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (dsp.start) value_q <= dsp.result;
    end

    assign nibble = value_q[{digit_idx, 2'b00} +: 4];

    // everything dark unless the latched operation asks for the display
    assign an  = show_q ? ~(anode_t'(1) << digit_idx) : '1;
    assign seg = show_q ? hex_to_seg(nibble) : '1;

endmodule

/* uart_tx/tx_sequencer.sv */
`include "out_config.svh"

module tx_sequencer import result_pkg::*, serial_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    dispatch_if.sender sp,
    output logic tx
);

    localparam int GAP_W = $clog2(`OUT_BYTE_GAP + 1);

    seq_state_t       state;
    result_t          res_q;
    logic [1:0]       byte_idx;
    logic [GAP_W-1:0] gap_cnt;
    logic             tx_start;
    logic             tx_busy;
    byte_t            tx_byte;

    // the serializer sees the start in the same cycle, so busy is up when WAIT_BUSY begins
    assign tx_start = (state == SEQ_SEND);
    assign tx_byte  = res_q[{byte_idx, 3'b000} +: 8];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= SEQ_IDLE;
            byte_idx   <= 2'd3;
            gap_cnt    <= '0;
            sp.tx_done <= 1'b0;
        end else begin
            sp.tx_done <= 1'b0;
            case (state)
                SEQ_IDLE: begin
                    if (sp.start) begin
                        byte_idx <= 2'd3;
                        state    <= SEQ_SEND;
                    end
                end
                SEQ_SEND: state <= SEQ_WAIT_BUSY;
                SEQ_WAIT_BUSY: begin
                    if (!tx_busy) begin
                        if (byte_idx == 2'd0) begin
                            sp.tx_done <= 1'b1;
                            state      <= SEQ_IDLE;
                        end else begin
                            gap_cnt <= '0;
                            state   <= SEQ_GAP;
                        end
                    end
                end
                default: begin
                    gap_cnt <= gap_cnt + 1'b1;
                    if (gap_cnt == GAP_W'(`OUT_BYTE_GAP - 1)) begin
                        byte_idx <= byte_idx - 1'b1;
                        state    <= SEQ_SEND;
                    end
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SEQ_IDLE && sp.start) res_q <= sp.result;
    end

    uart_tx_core u_uart_tx_core (
        .clk      (clk),
        .rst_n    (rst_n),
        .tx_start (tx_start),
        .tx_data  (tx_byte),
        .tx_busy  (tx_busy),
        .tx       (tx)
    );

endmodule

/* uart_tx/uart_tx_core.sv */
`include "out_config.svh"

module uart_tx_core import serial_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  tx_start,
    input  byte_t tx_data,
    output logic  tx_busy,
    output logic  tx
);

    localparam int CNT_W = $clog2(`OUT_CLKS_PER_BIT + 1);

    ser_state_t       state;
    logic [CNT_W-1:0] bit_cnt;
    logic [2:0]       bit_idx;
    logic             bit_end;
    byte_t            shreg;

    assign bit_end = (bit_cnt == CNT_W'(`OUT_CLKS_PER_BIT - 1));
    assign tx_busy = (state != SER_IDLE);

    // line idles high, data leaves LSB first from the bottom of the shift register
    assign tx = (state == SER_START) ? 1'b0 :
                (state == SER_DATA)  ? shreg[0] : 1'b1;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= SER_IDLE;
            bit_cnt <= '0;
            bit_idx <= '0;
        end else begin
            if (state == SER_IDLE || bit_end) bit_cnt <= '0;
            else bit_cnt <= bit_cnt + 1'b1;

            case (state)
                SER_IDLE: if (tx_start) state <= SER_START;
                SER_START: begin
                    if (bit_end) begin
                        bit_idx <= '0;
                        state   <= SER_DATA;
                    end
                end
                SER_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= SER_STOP;
                    end
                end
                default: if (bit_end) state <= SER_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == SER_IDLE && tx_start) shreg <= tx_data;
        else if (state == SER_DATA && bit_end) shreg <= shreg >> 1;
    end

endmodule

/* src/output_dispatch.sv */
module output_dispatch import result_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     req,
    input  op_code_t op_code,
    input  result_t  result_data,
    output logic     ack,
    dispatch_if.dispatcher dp
);

    typedef enum logic [1:0] {
        DSP_IDLE,
        DSP_RUN,
        DSP_ACK,
        DSP_RELEASE
    } dsp_state_t;

    dsp_state_t state;
    logic       tx_seen;
    logic       disp_seen;
    logic       both_done;

    // a done pulse in the current cycle counts as well as an earlier one
    assign both_done = (tx_seen | dp.tx_done) & (disp_seen | dp.disp_done);

    // ============================================================
    // handshake FSM
    // ============================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= DSP_IDLE;
            dp.start  <= 1'b0;
            dp.show   <= 1'b0;
            ack       <= 1'b0;
            tx_seen   <= 1'b0;
            disp_seen <= 1'b0;
        end else begin
            dp.start <= 1'b0;
            case (state)
                DSP_IDLE: begin
                    if (req) begin
                        // only average, Euclidean and Manhattan results are shown
                        dp.show   <= op_code[OP_AVG] | op_code[OP_EUC] | op_code[OP_MAN];
                        dp.start  <= 1'b1;
                        tx_seen   <= 1'b0;
                        disp_seen <= 1'b0;
                        state     <= DSP_RUN;
                    end
                end
                DSP_RUN: begin
                    if (dp.tx_done) tx_seen <= 1'b1;
                    if (dp.disp_done) disp_seen <= 1'b1;
                    if (both_done) begin
                        ack   <= 1'b1;
                        state <= DSP_ACK;
                    end
                end
                DSP_ACK: begin
                    if (!req) begin
                        ack   <= 1'b0;
                        state <= DSP_RELEASE;
                    end
                end
                default: begin
                    // one turnaround cycle so the next req is seen with ack already low
                    state <= DSP_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == DSP_IDLE && req) dp.result <= result_data;
    end

endmodule

/* common/dispatch_if.sv */
interface dispatch_if import result_pkg::*; ();

    result_t result;
    logic    show;
    // one cycle pulses, start from the dispatcher and one done per path
    logic    start;
    logic    tx_done;
    logic    disp_done;

    modport dispatcher (output result, output show, output start,
                        input tx_done, input disp_done);

    modport sender (input result, input start, output tx_done);

    modport display (input result, input show, input start, output disp_done);

endinterface

/* common/serial_pkg.sv */
package serial_pkg;

    typedef logic [7:0] byte_t;

    // bit level states of the 8N1 serializer
    typedef enum logic [1:0] {
        SER_IDLE,
        SER_START,
        SER_DATA,
        SER_STOP
    } ser_state_t;

    // byte level states of the four byte sequencer
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_SEND,
        SEQ_WAIT_BUSY,
        SEQ_GAP
    } seq_state_t;

endpackage

/* common/result_pkg.sv */
package result_pkg;

    // operation result coming from the arithmetic unit
    typedef logic [31:0] result_t;

    // one-hot operation flags ordered {dot, man, euc, avg, sum, read}
    typedef logic [5:0] op_code_t;

    // bit positions of the flags that light the display
    localparam int OP_AVG = 2;
    localparam int OP_EUC = 3;
    localparam int OP_MAN = 4;

    typedef logic [3:0] digit_t;

    // segments are active low, seg[6] is segment a and seg[0] is segment g
    typedef logic [6:0] seg_t;
    typedef logic [7:0] anode_t;

endpackage

/* common/out_config.svh */
`ifndef OUT_CONFIG_SVH
`define OUT_CONFIG_SVH

// ============================================================
// timing constants for the output stage
// ============================================================

// clock cycles per UART bit, a small value keeps simulation short
`define OUT_CLKS_PER_BIT 8

// idle cycles between two consecutive bytes on the line
`define OUT_BYTE_GAP 4

// clock cycles that each display digit stays lit
`define OUT_SCAN_DIV 4

`endif
